//--- brisc_config.svh
`ifndef BRISC_CONFIG_SVH
`define BRISC_CONFIG_SVH

// Datapath widths
`define XLEN 32
`define ILEN 32
`define ADDRESS_BITS 32

// Instruction cache geometry, 16 lines of four words
`define CACHE_LINE_LEN 128
`define CACHE_LINES 16

// Derived cache address split
`define LINE_WORDS (`CACHE_LINE_LEN / `ILEN)
`define WORD_SEL_BITS $clog2(`LINE_WORDS)
`define OFFSET_BITS $clog2(`CACHE_LINE_LEN / 8)
`define INDEX_BITS $clog2(`CACHE_LINES)
`define TAG_BITS (`ADDRESS_BITS - `INDEX_BITS - `OFFSET_BITS)

// Fixed program counter values
`define PC_BOOT 32'h0000_0100
`define PC_XCPT 32'h0000_0040

`endif

//--- brisc_pkg.sv
`include "brisc_config.svh"

package brisc_pkg;

  // Redirect request from later pipeline stages
  // xcpt wins over a taken branch
  typedef struct packed {
    logic xcpt;
    logic b_taken;
    logic [`ADDRESS_BITS-1:0] b_target;
  } redirect_t;

  // Registered result of the fetch stage
  typedef struct packed {
    logic valid;
    logic [`XLEN-1:0] pc;
    logic [`ILEN-1:0] instr;
  } fetch_out_t;

  // Line request to main memory, addr is line aligned
  typedef struct packed {
    logic valid;
    logic [`ADDRESS_BITS-1:0] addr;
  } mem_req_t;

  // Line returned by main memory, valid is a single cycle pulse
  typedef struct packed {
    logic valid;
    logic [`CACHE_LINE_LEN-1:0] data;
  } mem_fill_t;

endpackage

//--- ifetch_stage.sv
`include "brisc_config.svh"

module ifetch_stage (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   stall_fetch,
  input  brisc_pkg::redirect_t   redirect,
  input  logic                   hit,
  input  logic [`ILEN-1:0]       fetch_word,
  output logic [`XLEN-1:0]       pc,
  output brisc_pkg::fetch_out_t  fetch_out,
  output logic                   stall
);
  import brisc_pkg::*;

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_next;
  logic             update;
  fetch_out_t       fetch_d;

  // Cache miss holds the stage
  assign stall = ~hit;

  // PC and instruction register move together
  assign update = ~stall_fetch & hit;

  // Exception vector first, then branch target, else sequential
  always_comb begin
    if (redirect.xcpt) begin
      pc_next = `PC_XCPT;
    end else if (redirect.b_taken) begin
      pc_next = redirect.b_target;
    end else begin
      pc_next = pc_q + `XLEN'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= `PC_BOOT;
    end else if (update) begin
      pc_q <= pc_next;
    end
  end

  assign pc = pc_q;

  // Word being fetched this cycle, tagged with the PC it came from
  always_comb begin
    fetch_d.valid = update;
    fetch_d.pc    = pc_q;
    fetch_d.instr = fetch_word;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_out.valid <= 1'b0;
    end else begin
      fetch_out.valid <= fetch_d.valid;
    end
    // Payload holds its value when no update happens
    if (update) begin
      fetch_out.pc    <= fetch_d.pc;
      fetch_out.instr <= fetch_d.instr;
    end
  end

endmodule

//--- icache.sv
`include "brisc_config.svh"

module icache (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`XLEN-1:0]          pc,
  output logic                      hit,
  output logic [`ILEN-1:0]          fetch_word,
  output logic                      req_to_arbiter,
  output logic [`ADDRESS_BITS-1:0]  req_addr,
  input  logic                      grant,
  input  brisc_pkg::mem_fill_t      fill
);
  import brisc_pkg::*;

  // Storage, only valid bits are cleared
  logic [`CACHE_LINE_LEN-1:0] data_q [`CACHE_LINES];
  logic [`TAG_BITS-1:0]       tag_q  [`CACHE_LINES];
  logic [`CACHE_LINES-1:0]    valid_q;

  // Lookup fields of the current PC
  logic [`INDEX_BITS-1:0]    pc_index;
  logic [`TAG_BITS-1:0]      pc_tag;
  logic [`WORD_SEL_BITS-1:0] pc_word;
  logic [`CACHE_LINE_LEN-1:0] hit_line;

  // Outstanding miss, addr holds the line address being refilled
  mem_req_t                 miss_q;
  logic [`INDEX_BITS-1:0]   fill_index;
  logic [`TAG_BITS-1:0]     fill_tag;
  logic                     fill_write;
  logic                     miss_start;

  assign pc_index = pc[`OFFSET_BITS +: `INDEX_BITS];
  assign pc_tag   = pc[`ADDRESS_BITS-1 -: `TAG_BITS];
  assign pc_word  = pc[2 +: `WORD_SEL_BITS];

  // Same cycle lookup
  assign hit      = valid_q[pc_index] & (tag_q[pc_index] == pc_tag);
  assign hit_line = data_q[pc_index];

  always_comb begin
    fetch_word = hit_line[pc_word * `ILEN +: `ILEN];
  end

  // New miss only when no refill is already in flight
  assign miss_start = ~hit & ~miss_q.valid;

  // Fill counts only while the arbiter still grants this side
  assign fill_write = fill.valid & grant & miss_q.valid;

  assign fill_index = miss_q.addr[`OFFSET_BITS +: `INDEX_BITS];
  assign fill_tag   = miss_q.addr[`ADDRESS_BITS-1 -: `TAG_BITS];

  always_ff @(posedge clk) begin
    if (reset) begin
      miss_q.valid <= 1'b0;
    end else if (miss_start) begin
      miss_q.valid <= 1'b1;
    end else if (fill_write) begin
      miss_q.valid <= 1'b0;
    end
    if (miss_start) begin
      miss_q.addr <= {pc[`ADDRESS_BITS-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
    end
  end

  // Level held until the fill arrives
  assign req_to_arbiter = miss_q.valid;
  assign req_addr       = miss_q.addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else if (fill_write) begin
      valid_q[fill_index] <= 1'b1;
    end
  end

  // Line and tag written by the refill, hit follows next cycle
  always_ff @(posedge clk) begin
    if (fill_write) begin
      data_q[fill_index] <= fill.data;
      tag_q[fill_index]  <= fill_tag;
    end
  end

endmodule

//--- mem_arbiter.sv
`include "brisc_config.svh"

module mem_arbiter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      icache_req,
  input  logic [`ADDRESS_BITS-1:0]  icache_addr,
  input  logic                      data_req,
  input  logic [`ADDRESS_BITS-1:0]  data_addr,
  output logic                      icache_grant,
  output brisc_pkg::mem_fill_t      icache_fill,
  output brisc_pkg::mem_fill_t      data_fill,
  output brisc_pkg::mem_req_t       mem_req,
  input  brisc_pkg::mem_fill_t      mem_fill
);
  import brisc_pkg::*;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ISSUE,
    ARB_WAIT
  } arb_state_e;

  arb_state_e               state_q;
  // Owner and last served use 1 for the data side
  logic                     owner_q;
  logic                     last_q;
  logic [`ADDRESS_BITS-1:0] addr_q;
  logic                     pick_data;
  logic                     data_grant;
  logic                     fill_done;

  // Data side wins alone, or on a tie when the cache was served last
  assign pick_data = data_req & (~icache_req | ~last_q);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ARB_IDLE;
      owner_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (icache_req | data_req) begin
            state_q <= ARB_ISSUE;
            owner_q <= pick_data;
          end
        end
        ARB_ISSUE: state_q <= ARB_WAIT;
        ARB_WAIT: begin
          if (mem_fill.valid) begin
            state_q <= ARB_IDLE;
            last_q  <= owner_q;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // Address of the chosen requester
  always_ff @(posedge clk) begin
    if (state_q == ARB_IDLE) begin
      addr_q <= pick_data ? data_addr : icache_addr;
    end
  end

  // Grant held from choice until the fill
  assign icache_grant = (state_q != ARB_IDLE) & ~owner_q;
  assign data_grant   = (state_q != ARB_IDLE) & owner_q;

  // One cycle request pulse
  assign mem_req.valid = (state_q == ARB_ISSUE);
  assign mem_req.addr  = addr_q;

  assign fill_done = (state_q == ARB_WAIT) & mem_fill.valid;

  // Fill steered to the owner only
  assign icache_fill.valid = fill_done & icache_grant;
  assign icache_fill.data  = mem_fill.data;
  assign data_fill.valid   = fill_done & data_grant;
  assign data_fill.data    = mem_fill.data;

endmodule

//--- fetch_top.sv
`include "brisc_config.svh"

module fetch_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stall_fetch,
  input  brisc_pkg::redirect_t      redirect,
  input  logic                      data_req,
  input  logic [`ADDRESS_BITS-1:0]  data_addr,
  input  brisc_pkg::mem_fill_t      mem_fill,
  output brisc_pkg::fetch_out_t     fetch_out,
  output logic                      stall,
  output brisc_pkg::mem_req_t       mem_req,
  output brisc_pkg::mem_fill_t      data_fill
);
  import brisc_pkg::*;

  logic [`XLEN-1:0]         pc;
  logic                     hit;
  logic [`ILEN-1:0]         fetch_word;
  logic                     icache_req;
  logic [`ADDRESS_BITS-1:0] icache_addr;
  logic                     icache_grant;
  mem_fill_t                icache_fill;

  ifetch_stage u_fetch (
    .clk         (clk),
    .reset       (reset),
    .stall_fetch (stall_fetch),
    .redirect    (redirect),
    .hit         (hit),
    .fetch_word  (fetch_word),
    .pc          (pc),
    .fetch_out   (fetch_out),
    .stall       (stall)
  );

  // Refills continue regardless of stall_fetch
  icache u_icache (
    .clk            (clk),
    .reset          (reset),
    .pc             (pc),
    .hit            (hit),
    .fetch_word     (fetch_word),
    .req_to_arbiter (icache_req),
    .req_addr       (icache_addr),
    .grant          (icache_grant),
    .fill           (icache_fill)
  );

  mem_arbiter u_arbiter (
    .clk          (clk),
    .reset        (reset),
    .icache_req   (icache_req),
    .icache_addr  (icache_addr),
    .data_req     (data_req),
    .data_addr    (data_addr),
    .icache_grant (icache_grant),
    .icache_fill  (icache_fill),
    .data_fill    (data_fill),
    .mem_req      (mem_req),
    .mem_fill     (mem_fill)
  );

endmodule

//--- fetch_sva.sv
`include "brisc_config.svh"

module fetch_sva (
  input logic                clk,
  input logic                reset,
  input brisc_pkg::mem_req_t  mem_req,
  input brisc_pkg::mem_fill_t mem_fill,
  input logic                icache_req,
  input logic                data_req,
  input logic                icache_grant,
  input logic                data_grant
);
  timeunit 1ns;
  timeprecision 1ps;
  import brisc_pkg::*;

  // Set by a request, cleared by its fill
  logic outstanding;

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 1'b0;
    end else if (mem_req.valid) begin
      outstanding <= 1'b1;
    end else if (mem_fill.valid) begin
      outstanding <= 1'b0;
    end
  end

  req_pulse: assert property (@(posedge clk) disable iff (reset)
    mem_req.valid |=> !mem_req.valid)
    else $error("mem_req.valid longer than one cycle");

  one_outstanding: assert property (@(posedge clk) disable iff (reset)
    !(mem_req.valid && outstanding))
    else $error("new memory request before previous fill");

  // A grant only goes to a side that still holds its request
  grant_to_requester: assert property (@(posedge clk) disable iff (reset)
    !(icache_grant && !icache_req) && !(data_grant && !data_req))
    else $error("grant given to a requester that is not asking");

endmodule

bind mem_arbiter fetch_sva u_sva (
  .clk          (clk),
  .reset        (reset),
  .mem_req      (mem_req),
  .mem_fill     (mem_fill),
  .icache_req   (icache_req),
  .data_req     (data_req),
  .icache_grant (icache_grant),
  .data_grant   (data_grant)
);

//--- tb_fetch.sv
`include "brisc_config.svh"

module tb_fetch;
  timeunit 1ns;
  timeprecision 1ps;
  import brisc_pkg::*;

  logic       clk;
  logic       reset;
  logic       stall_fetch;
  redirect_t  redirect;
  logic       data_req;
  logic [`ADDRESS_BITS-1:0] data_addr;
  mem_fill_t  mem_fill;
  fetch_out_t fetch_out;
  logic       stall;
  mem_req_t   mem_req;
  mem_fill_t  data_fill;

  integer seed = 32'h66322d3a;
  int req_count [logic [31:0]];
  logic [31:0] exp_pc;
  logic [31:0] pend_pc;
  logic        pend_valid;
  logic        stall_exp;
  logic [31:0] fill_addr;
  logic [23:0] line_tag [16];
  logic [15:0] line_ok;
  int          fetch_count;
  int          data_fill_count;

  fetch_top dut (
    .clk         (clk),
    .reset       (reset),
    .stall_fetch (stall_fetch),
    .redirect    (redirect),
    .data_req    (data_req),
    .data_addr   (data_addr),
    .mem_fill    (mem_fill),
    .fetch_out   (fetch_out),
    .stall       (stall),
    .mem_req     (mem_req),
    .data_fill   (data_fill)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Memory contents: address hash rotated by the word select bits
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] w;
    int r;
    w = addr ^ 32'hA5A5_0000;
    r = addr[3:2];
    return (w << r) | (w >> (32 - r));
  endfunction

  // Word 0 sits in the low bits of the line
  function automatic logic [127:0] line_of(input logic [31:0] addr);
    logic [127:0] line;
    logic [31:0] base;
    base = {addr[31:4], 4'b0000};
    for (int i = 0; i < 4; i++) begin
      line[i*32 +: 32] = mem_word(base + 32'(4 * i));
    end
    return line;
  endfunction

  // Expected PC after an update edge
  function automatic logic [31:0] next_pc(input logic [31:0] pc, input redirect_t rd);
    if (rd.xcpt) begin
      return `PC_XCPT;
    end else if (rd.b_taken) begin
      return rd.b_target;
    end
    return pc + 32'd4;
  endfunction

  function automatic int count_of(input logic [31:0] addr);
    if (req_count.exists(addr)) begin
      return req_count[addr];
    end
    return 0;
  endfunction

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic give_up(input string msg);
    $display("Timeout: %s at t=%0t", msg, $time);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic wait_pc(input logic [31:0] pc);
    int n;
    n = 0;
    while (exp_pc !== pc) begin
      @(posedge clk);
      #5;
      n++;
      if (n > 400) begin
        give_up($sformatf("PC never reached %h", pc));
      end
    end
  endtask

  // Present a redirect for the fetch of at_pc, then hold it until an update edge
  task automatic branch_at(input logic [31:0] at_pc, input logic [31:0] target,
                           input logic xcpt);
    int n;
    wait_pc(at_pc);
    redirect.xcpt     = xcpt;
    redirect.b_taken  = 1'b1;
    redirect.b_target = target;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 400) begin
        give_up("redirect never taken by fetch stage");
      end
    end while (stall || stall_fetch);
    @(posedge clk);
    #5;
    redirect = '0;
  endtask

  // Main memory, one line per request after 2 to 9 cycles
  initial begin
    int delay;
    logic [31:0] addr;
    mem_fill = '0;
    forever begin
      @(negedge clk);
      if (!reset && mem_req.valid) begin
        addr = mem_req.addr;
        req_count[addr] = count_of(addr) + 1;
        delay = 2 + ($unsigned($random(seed)) % 8);
        repeat (delay) @(posedge clk);
        #5;
        fill_addr      = addr;
        mem_fill.valid = 1'b1;
        mem_fill.data  = line_of(addr);
        @(posedge clk);
        #5;
        mem_fill.valid = 1'b0;
      end
    end
  end

  // Comparison process, sampled mid cycle where all signals are stable
  always @(negedge clk) begin
    if (reset) begin
      exp_pc     = `PC_BOOT;
      pend_valid = 1'b0;
      line_ok    = '0;
      fetch_count = 0;
      data_fill_count = 0;
    end else begin
      check("fetch_out.valid", fetch_out.valid, pend_valid);
      if (pend_valid) begin
        check("fetch_out.pc", fetch_out.pc, pend_pc);
        check("fetch_out.instr", fetch_out.instr, mem_word(pend_pc));
        fetch_count++;
      end
      // Direct mapped lookup of the current PC, index 7:4 and tag 31:8
      stall_exp = !(line_ok[exp_pc[7:4]] && line_tag[exp_pc[7:4]] == exp_pc[31:8]);
      check("stall", stall, stall_exp);
      pend_valid = !stall_fetch && !stall_exp;
      if (pend_valid) begin
        pend_pc = exp_pc;
        exp_pc  = next_pc(exp_pc, redirect);
      end
      // Instruction refill is written at the next edge
      if (mem_fill.valid && !(data_req && fill_addr == data_addr)) begin
        line_ok[fill_addr[7:4]]  = 1'b1;
        line_tag[fill_addr[7:4]] = fill_addr[31:8];
      end
      if (data_fill.valid) begin
        data_fill_count++;
        check("data_fill.data", data_fill.data, line_of(data_addr));
      end
    end
  end

  initial begin
    int n;
    reset       = 1'b1;
    stall_fetch = 1'b0;
    redirect    = '0;
    data_req    = 1'b0;
    data_addr   = '0;
    repeat (16) @(posedge clk);
    #5;
    reset = 1'b0;

    // Straight line from boot, then branch and exception over branch
    branch_at(32'h12c, 32'h200, 1'b0);
    branch_at(32'h20c, 32'h300, 1'b1);

    // Freeze the stage for ten cycles
    wait_pc(32'h50);
    stall_fetch = 1'b1;
    repeat (10) @(posedge clk);
    #5;
    stall_fetch = 1'b0;

    // Loop over two lines, filled only once
    branch_at(32'h68, 32'h400, 1'b0);
    repeat (3) begin
      branch_at(32'h41c, 32'h400, 1'b0);
    end
    check("req_count[400]", count_of(32'h400), 1);
    check("req_count[410]", count_of(32'h410), 1);

    // Line 0x500 shares the index with 0x400
    branch_at(32'h41c, 32'h500, 1'b0);
    branch_at(32'h50c, 32'h400, 1'b0);
    branch_at(32'h404, 32'h600, 1'b0);
    check("req_count[400]", count_of(32'h400), 2);

    // Data request racing the instruction misses
    data_addr = 32'h800;
    data_req  = 1'b1;
    n = 0;
    while (!data_fill.valid) begin
      @(negedge clk);
      n++;
      if (n > 200) begin
        give_up("no data fill for the data request");
      end
    end
    @(posedge clk);
    #5;
    data_req = 1'b0;
    wait_pc(32'h62c);
    repeat (20) @(posedge clk);
    check("data_fill_count", data_fill_count, 1);
    check("req_count[800]", count_of(32'h800), 1);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- tb.f
+incdir+.
brisc_pkg.sv
ifetch_stage.sv
icache.sv
mem_arbiter.sv
fetch_top.sv
fetch_sva.sv
tb_fetch.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_fetch -o sim_fetch

# Simulator exit status is not trusted, the log decides
./obj_dir/sim_fetch > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
